/* axi_mux_cfg_pkg.sv */
// Size and depth constants of the AXI4 write multiplexer
// Imported by the channel package and by every RTL module

`default_nettype none

package axi_mux_cfg_pkg;

  // ------------------------------------------------
  // Port count and ID widths
  // ------------------------------------------------
  localparam int NUM_PORTS  = 4;
  localparam int PORT_IDX_W = 2;                     // $clog2(NUM_PORTS)
  localparam int SLV_ID_W   = 4;
  localparam int MST_ID_W   = SLV_ID_W + PORT_IDX_W; // Port index sits above the slave ID

  // Payload widths
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Order FIFO
  localparam int MAX_W_TRANS = 8;  // Writes in flight between AW and the last W beat
  localparam int FIFO_CNT_W  = 4;  // Occupancy 0..MAX_W_TRANS
  localparam int FIFO_PTR_W  = 3;  // Read and write pointers

endpackage

`default_nettype wire

/* axi_mux_chan_pkg.sv */
// Channel payload types for the slave and master sides of the write multiplexer
// The master ID is a union so the port index can be read or written on its own

`default_nettype none

package axi_mux_chan_pkg;
  import axi_mux_cfg_pkg::*;

  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MST_ID_W-1:0]   mst_id_t;

  // ------------------------------------------------
  // Master ID, port index prepended to slave ID
  // ------------------------------------------------
  typedef struct packed {
    port_idx_t port;  // Upper bits
    slv_id_t   id;
  } mst_id_s;

  typedef union packed {
    mst_id_t raw;
    mst_id_s split;
  } mst_id_u;

  // ------------------------------------------------
  // AW channel
  // ------------------------------------------------
  typedef struct packed {
    slv_id_t            id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
  } slv_aw_t;

  typedef struct packed {
    mst_id_u            id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
  } mst_aw_t;

  // W channel, identical on both sides
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_beat_t;

  // ------------------------------------------------
  // B channel
  // ------------------------------------------------
  typedef struct packed {
    slv_id_t    id;
    logic [1:0] resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_u    id;
    logic [1:0] resp;
  } mst_b_t;

endpackage

`default_nettype wire

/* aw_arbiter.sv */
// Round-robin arbiter for the slave AW channels with lock-in
// Extends the winner's ID with its port index before handing it to the AW FSM

`timescale 1ns/1ps
`default_nettype none

module aw_arbiter
  import axi_mux_cfg_pkg::*;
  import axi_mux_chan_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic    [NUM_PORTS-1:0]   slv_aw_valid_i,
  input  wire slv_aw_t [NUM_PORTS-1:0]   slv_aw_i,
  output logic         [NUM_PORTS-1:0]   slv_aw_ready_o,
  output logic                           arb_valid_o,
  output mst_aw_t                        arb_aw_o,
  input  wire logic                      arb_ready_i
);

  port_idx_t rr_q;        // Highest priority port
  logic      lock_q;      // Grant held across a stalled handshake
  port_idx_t lock_idx_q;
  port_idx_t sel;
  logic      any_req;

  // ------------------------------------------------
  // Grant selection
  // ------------------------------------------------
  always_comb begin
    port_idx_t cand;
    any_req = 1'b0;
    sel     = rr_q;
    cand    = rr_q;
    if (lock_q) begin
      sel     = lock_idx_q;
      any_req = slv_aw_valid_i[lock_idx_q];
    end else begin
      for (int k = 0; k < NUM_PORTS; k++) begin
        cand = port_idx_t'((int'(rr_q) + k) % NUM_PORTS);
        if (!any_req && slv_aw_valid_i[cand]) begin  // First requester from the pointer on
          any_req = 1'b1;
          sel     = cand;
        end
      end
    end
  end

  assign arb_valid_o = any_req;

  always_comb begin
    slv_aw_ready_o      = '0;
    slv_aw_ready_o[sel] = any_req & arb_ready_i;
  end

  // ID prepend through the split view
  always_comb begin
    arb_aw_o                = '0;
    arb_aw_o.id.split.port  = sel;
    arb_aw_o.id.split.id    = slv_aw_i[sel].id;
    arb_aw_o.addr           = slv_aw_i[sel].addr;
    arb_aw_o.len            = slv_aw_i[sel].len;
  end

  // ------------------------------------------------
  // Pointer and lock state
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= arb_valid_o & ~arb_ready_i;
      lock_idx_q <= sel;
      if (arb_valid_o && arb_ready_i) begin
        // Priority moves to the port after the winner
        rr_q <= (sel == port_idx_t'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

  // Stalled grant keeps its port until the handshake completes
  a_lock_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    arb_valid_o && !arb_ready_i |=>
      arb_valid_o && (arb_aw_o.id.split.port == $past(arb_aw_o.id.split.port)));

endmodule

`default_nettype wire

/* aw_lock_fsm.sv */
// AW handshake control between arbiter, order FIFO and master port
// Pushes each arbitration decision once, then holds valid until the master takes it

`timescale 1ns/1ps
`default_nettype none

module aw_lock_fsm
  import axi_mux_chan_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,
  input  wire logic    arb_valid_i,
  input  wire mst_aw_t arb_aw_i,
  output logic         arb_ready_o,
  input  wire logic    fifo_full_i,
  output logic         push_o,
  output port_idx_t    push_idx_o,
  output logic         mst_aw_valid_o,
  output mst_aw_t      mst_aw_o,
  input  wire logic    mst_aw_ready_i
);

  typedef enum logic {
    IDLE,
    LOCKED   // Decision already in the FIFO, waiting for the master
  } state_e;

  state_e state_q, state_d;

  assign mst_aw_o   = arb_aw_i;
  assign push_idx_o = arb_aw_i.id.split.port;

  always_comb begin
    state_d        = state_q;
    push_o         = 1'b0;
    mst_aw_valid_o = 1'b0;
    arb_ready_o    = 1'b0;
    case (state_q)
      IDLE: begin
        if (arb_valid_i && !fifo_full_i) begin
          mst_aw_valid_o = 1'b1;
          push_o         = 1'b1;
          arb_ready_o    = mst_aw_ready_i;
          if (!mst_aw_ready_i) state_d = LOCKED;  // No second push next cycle
        end
      end
      LOCKED: begin
        mst_aw_valid_o = 1'b1;
        arb_ready_o    = mst_aw_ready_i;
        if (mst_aw_ready_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) state_q <= IDLE;
    else       state_q <= state_d;
  end

  // Master side sees a stable request until accepted
  a_aw_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o));

endmodule

`default_nettype wire

/* w_order_fifo.sv */
// Order FIFO of port indices, one entry per accepted AW
// Its head names the port whose W burst goes to the master next

`timescale 1ns/1ps
`default_nettype none

module w_order_fifo
  import axi_mux_cfg_pkg::*;
  import axi_mux_chan_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire logic      push_i,
  input  wire port_idx_t push_idx_i,
  input  wire logic      pop_i,
  output logic           full_o,
  output logic           empty_o,
  output port_idx_t      head_idx_o
);

  port_idx_t               mem [MAX_W_TRANS];
  logic [FIFO_PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [FIFO_CNT_W-1:0]   cnt_q;

  assign full_o     = (cnt_q == FIFO_CNT_W'(MAX_W_TRANS));
  assign empty_o    = (cnt_q == '0);
  assign head_idx_o = mem[rd_ptr_q];  // Valid only while not empty

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr_q] <= push_idx_i;
  end

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;     // Both or neither
      endcase
    end
  end

  // Guarded by the AW FSM and the W switch
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* w_switch.sv */
// W channel switch, forwards whole bursts from the port at the order FIFO head
// Pops the FIFO when the last beat of a burst is accepted by the master

`timescale 1ns/1ps
`default_nettype none

module w_switch
  import axi_mux_cfg_pkg::*;
  import axi_mux_chan_pkg::*;
(
  input  wire logic                     empty_i,
  input  wire port_idx_t                head_idx_i,
  output logic                          pop_o,
  input  wire logic    [NUM_PORTS-1:0]  slv_w_valid_i,
  input  wire w_beat_t [NUM_PORTS-1:0]  slv_w_i,
  output logic         [NUM_PORTS-1:0]  slv_w_ready_o,
  output logic                          mst_w_valid_o,
  output w_beat_t                       mst_w_o,
  input  wire logic                     mst_w_ready_i
);

  logic head_ok;

  assign head_ok = ~empty_i;

  // Data follows the head port, valid only while an AW is waiting
  assign mst_w_o       = slv_w_i[head_idx_i];
  assign mst_w_valid_o = head_ok & slv_w_valid_i[head_idx_i];

  always_comb begin
    slv_w_ready_o             = '0;
    slv_w_ready_o[head_idx_i] = head_ok & mst_w_ready_i;  // All other ports stalled
  end

  // End of burst
  assign pop_o = mst_w_valid_o & mst_w_ready_i & mst_w_o.last;

endmodule

`default_nettype wire

/* b_router.sv */
// B response router, selects the slave port from the ID prefix
// The prefix is stripped so each port sees its own ID again

`timescale 1ns/1ps
`default_nettype none

module b_router
  import axi_mux_cfg_pkg::*;
  import axi_mux_chan_pkg::*;
(
  input  wire logic                     mst_b_valid_i,
  input  wire mst_b_t                   mst_b_i,
  output logic                          mst_b_ready_o,
  output logic        [NUM_PORTS-1:0]   slv_b_valid_o,
  output slv_b_t      [NUM_PORTS-1:0]   slv_b_o,
  input  wire logic   [NUM_PORTS-1:0]   slv_b_ready_i
);

  port_idx_t dst;

  assign dst           = mst_b_i.id.split.port;
  assign mst_b_ready_o = slv_b_ready_i[dst];

  always_comb begin
    slv_b_valid_o      = '0;
    slv_b_valid_o[dst] = mst_b_valid_i;
    for (int p = 0; p < NUM_PORTS; p++) begin
      slv_b_o[p].id   = mst_b_i.id.split.id;  // Broadcast, only dst has valid
      slv_b_o[p].resp = mst_b_i.resp;
    end
  end

endmodule

`default_nettype wire

/* axi_wmux_top.sv */
// Write half of an AXI4 multiplexer joining NUM_PORTS slave ports to one master port
// AW arbitration, W ordering and B routing, all without data path registers

`timescale 1ns/1ps
`default_nettype none

module axi_wmux_top
  import axi_mux_cfg_pkg::*;
  import axi_mux_chan_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  // Slave ports
  input  wire logic    [NUM_PORTS-1:0]  slv_aw_valid_i,
  input  wire slv_aw_t [NUM_PORTS-1:0]  slv_aw_i,
  output logic         [NUM_PORTS-1:0]  slv_aw_ready_o,
  input  wire logic    [NUM_PORTS-1:0]  slv_w_valid_i,
  input  wire w_beat_t [NUM_PORTS-1:0]  slv_w_i,
  output logic         [NUM_PORTS-1:0]  slv_w_ready_o,
  output logic         [NUM_PORTS-1:0]  slv_b_valid_o,
  output slv_b_t       [NUM_PORTS-1:0]  slv_b_o,
  input  wire logic    [NUM_PORTS-1:0]  slv_b_ready_i,
  // Master port
  output logic                          mst_aw_valid_o,
  output mst_aw_t                       mst_aw_o,
  input  wire logic                     mst_aw_ready_i,
  output logic                          mst_w_valid_o,
  output w_beat_t                       mst_w_o,
  input  wire logic                     mst_w_ready_i,
  input  wire logic                     mst_b_valid_i,
  input  wire mst_b_t                   mst_b_i,
  output logic                          mst_b_ready_o
);

  // ------------------------------------------------
  // Internal links
  // ------------------------------------------------
  logic      arb_valid, arb_ready;
  mst_aw_t   arb_aw;
  logic      push, pop;
  port_idx_t push_idx, head_idx;
  logic      fifo_full, fifo_empty;

  aw_arbiter u_aw_arbiter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .arb_valid_o    (arb_valid),
    .arb_aw_o       (arb_aw),
    .arb_ready_i    (arb_ready)
  );

  aw_lock_fsm u_aw_lock_fsm (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .arb_valid_i    (arb_valid),
    .arb_aw_i       (arb_aw),
    .arb_ready_o    (arb_ready),
    .fifo_full_i    (fifo_full),
    .push_o         (push),
    .push_idx_o     (push_idx),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_ready_i (mst_aw_ready_i)
  );

  w_order_fifo u_w_order_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .push_i     (push),
    .push_idx_i (push_idx),
    .pop_i      (pop),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty),
    .head_idx_o (head_idx)
  );

  w_switch u_w_switch (
    .empty_i       (fifo_empty),
    .head_idx_i    (head_idx),
    .pop_o         (pop),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_i       (slv_w_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_o       (mst_w_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  b_router u_b_router (
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_i       (mst_b_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_o       (slv_b_o),
    .slv_b_ready_i (slv_b_ready_i)
  );

endmodule

`default_nettype wire

/* tb_axi_wmux.sv */
// Random testbench for the AXI4 write multiplexer with reference and master-side models
// Run from the project root with the file list, top module tb_axi_wmux

`timescale 1ns/1ps
`default_nettype none

module tb_axi_wmux
  import axi_mux_cfg_pkg::*;
  import axi_mux_chan_pkg::*;
();

  localparam int WRITES_PER_PORT = 50;
  localparam int NUM_WRITES      = NUM_PORTS * WRITES_PER_PORT;
  localparam int MAX_CYCLES      = NUM_WRITES * 100;  // 20000
  localparam int STALL_START     = 200;               // mst_w_ready_i held low
  localparam int STALL_END       = 500;

  logic                           clk_i, rst_i;
  logic    [NUM_PORTS-1:0]        slv_aw_valid_i, slv_aw_ready_o;
  slv_aw_t [NUM_PORTS-1:0]        slv_aw_i;
  logic    [NUM_PORTS-1:0]        slv_w_valid_i, slv_w_ready_o;
  w_beat_t [NUM_PORTS-1:0]        slv_w_i;
  logic    [NUM_PORTS-1:0]        slv_b_valid_o, slv_b_ready_i;
  slv_b_t  [NUM_PORTS-1:0]        slv_b_o;
  logic                           mst_aw_valid_o, mst_aw_ready_i;
  mst_aw_t                        mst_aw_o;
  logic                           mst_w_valid_o, mst_w_ready_i;
  w_beat_t                        mst_w_o;
  logic                           mst_b_valid_i, mst_b_ready_o;
  mst_b_t                         mst_b_i;

  // ------------------------------------------------
  // Model state
  // ------------------------------------------------
  slv_aw_t  aw_log [NUM_PORTS][WRITES_PER_PORT];  // Every AW a port issues, in order
  int       n_iss [NUM_PORTS], n_acc [NUM_PORTS], n_mst [NUM_PORTS];
  int       n_wb [NUM_PORTS], beat [NUM_PORTS];   // Port-side W progress
  int       others [NUM_PORTS], b_got [NUM_PORTS];
  mst_aw_t  order_q [$];                          // Master AW order, W must follow it
  mst_id_t  b_pend [$];                           // Bursts done, B not yet sent
  logic [NUM_PORTS-1:0] aw_fire, w_fire;
  logic     b_fire, maw, mw;
  int       aw_done, w_done, b_done, mw_beat, max_out, aw_stall_end;
  int       aw_port, w_port, b_port, k;
  int       err [5], chk [5], total_err, total_chk;
  int unsigned cycle;
  bit       w_stall, stall_was, timed_out;
  slv_aw_t  aw_new, exp_aw;
  w_beat_t  w_new;
  mst_b_t   b_new;
  string    test_name [5] = '{"AW ID prepend", "W burst order", "B routing",
                              "W back-pressure limit", "Round-robin fairness"};

  axi_wmux_top UUT (.*);

  task automatic compare_value(input int t, input string name,
                               input logic [63:0] got, input logic [63:0] exp);
    chk[t]++;
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      err[t]++;
    end
  endtask

  task automatic check_true(input int t, input bit ok, input string what);
    chk[t]++;
    assert (ok) else begin
      $display("Error at %0t ns: %s", $time, what);
      err[t]++;
    end
  endtask

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // ------------------------------------------------
  // Drivers, slave ports and master-side slave model
  // ------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycle++;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (aw_fire[p] || !slv_aw_valid_i[p]) begin
          slv_aw_valid_i[p] <= 1'b0;
          if (n_iss[p] < WRITES_PER_PORT && $urandom_range(1, 0) == 0) begin
            aw_new.id           = slv_id_t'($urandom);
            aw_new.addr         = $urandom;
            aw_new.len          = LEN_W'($urandom_range(3, 0));
            aw_log[p][n_iss[p]] = aw_new;
            n_iss[p]++;
            slv_aw_valid_i[p] <= 1'b1;
            slv_aw_i[p]       <= aw_new;
          end
        end
        if (w_fire[p]) begin
          if (beat[p] == int'(aw_log[p][n_wb[p]].len)) begin
            beat[p] = 0;
            n_wb[p]++;
          end else begin
            beat[p]++;
          end
        end
        if (w_fire[p] || !slv_w_valid_i[p]) begin
          slv_w_valid_i[p] <= 1'b0;
          if (n_wb[p] < n_acc[p] && $urandom_range(3, 0) != 0) begin  // Random gaps
            w_new.data = $urandom;
            w_new.strb = STRB_W'($urandom);
            w_new.last = (beat[p] == int'(aw_log[p][n_wb[p]].len));
            slv_w_valid_i[p] <= 1'b1;
            slv_w_i[p]       <= w_new;
          end
        end
      end
      w_stall = (cycle >= STALL_START && cycle < STALL_END);
      mst_aw_ready_i <= ($urandom_range(3, 0) != 0);
      mst_w_ready_i  <= w_stall ? 1'b0 : ($urandom_range(3, 0) != 0);
      slv_b_ready_i  <= NUM_PORTS'($urandom);
      if (b_fire || !mst_b_valid_i) begin
        mst_b_valid_i <= 1'b0;
        if (b_pend.size() > 0 && $urandom_range(1, 0) == 0) begin
          k = $urandom_range(b_pend.size() - 1, 0);  // Any pending write, random order
          b_new.id.raw = b_pend[k];
          b_new.resp   = 2'($urandom);
          b_pend.delete(k);
          mst_b_valid_i <= 1'b1;
          mst_b_i       <= b_new;
        end
      end
    end
  end

  // ------------------------------------------------
  // Monitor, sampled mid-cycle where all signals are settled
  // ------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_i) begin
      aw_fire = slv_aw_valid_i & slv_aw_ready_o;
      w_fire  = slv_w_valid_i & slv_w_ready_o;
      b_fire  = mst_b_valid_i & mst_b_ready_o;
      maw     = mst_aw_valid_o & mst_aw_ready_i;
      mw      = mst_w_valid_o & mst_w_ready_i;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (aw_fire[p]) begin
          n_acc[p]++;
          others[p] = 0;
        end else if (!slv_aw_valid_i[p]) begin
          others[p] = 0;
        end else if (aw_fire != '0) begin
          others[p]++;  // Lost a grant while requesting
          check_true(4, others[p] < NUM_PORTS,
                     $sformatf("port %0d passed over %0d times in a row", p, others[p]));
        end
      end
      if (maw) begin
        aw_port = int'(mst_aw_o.id.raw >> SLV_ID_W);
        compare_value(0, "slv_aw_ready_o", slv_aw_ready_o, 1 << aw_port);
        if (n_mst[aw_port] < n_acc[aw_port]) begin
          exp_aw = aw_log[aw_port][n_mst[aw_port]];
          compare_value(0, "mst_aw_o.id slave bits", mst_aw_o.id.raw[SLV_ID_W-1:0], exp_aw.id);
          compare_value(0, "mst_aw_o.addr", mst_aw_o.addr, exp_aw.addr);
          compare_value(0, "mst_aw_o.len", mst_aw_o.len, exp_aw.len);
          n_mst[aw_port]++;
        end else begin
          check_true(0, 1'b0, $sformatf("master AW names port %0d, which has no open AW", aw_port));
        end
        order_q.push_back(mst_aw_o);
        aw_done++;
        check_true(3, aw_done - w_done <= MAX_W_TRANS,
                   $sformatf("%0d writes in flight, more than the FIFO holds", aw_done - w_done));
      end else if (aw_fire != '0) begin
        check_true(0, 1'b0, "slave AW accepted with no AW at the master port");
      end
      if (w_stall && aw_done - w_done > max_out) max_out = aw_done - w_done;
      if (stall_was && !w_stall) aw_stall_end = aw_done;
      stall_was = w_stall;
      if (mw) begin
        if (order_q.size() == 0) begin
          check_true(1, 1'b0, "W beat at the master port with no open burst");
        end else begin
          w_port = int'(order_q[0].id.raw >> SLV_ID_W);
          compare_value(1, "slv_w_ready_o", slv_w_ready_o, 1 << w_port);
          compare_value(1, "mst_w_o.data", mst_w_o.data, slv_w_i[w_port].data);
          compare_value(1, "mst_w_o.strb", mst_w_o.strb, slv_w_i[w_port].strb);
          compare_value(1, "mst_w_o.last", mst_w_o.last, mw_beat == int'(order_q[0].len));
          if (mw_beat == int'(order_q[0].len)) begin
            b_pend.push_back(order_q[0].id.raw);
            order_q.delete(0);
            mw_beat = 0;
            w_done++;
          end else begin
            mw_beat++;
          end
        end
      end else if (w_fire != '0) begin
        check_true(1, 1'b0, "slave W beat accepted with no beat at the master port");
      end
      if (mst_b_valid_i) begin
        b_port = int'(mst_b_i.id.raw >> SLV_ID_W);
        compare_value(2, "slv_b_valid_o", slv_b_valid_o, 1 << b_port);
        compare_value(2, "mst_b_ready_o", mst_b_ready_o, slv_b_ready_i[b_port]);
        if (b_fire) begin
          compare_value(2, "slv_b_o.id", slv_b_o[b_port].id, mst_b_i.id.raw[SLV_ID_W-1:0]);
          compare_value(2, "slv_b_o.resp", slv_b_o[b_port].resp, mst_b_i.resp);
          b_got[b_port]++;
          b_done++;
        end
      end else if (slv_b_valid_o != '0) begin
        compare_value(2, "slv_b_valid_o", slv_b_valid_o, '0);
      end
    end
  end

  initial begin
    void'($urandom(36676));
    rst_i          = 1'b1;
    slv_aw_valid_i = '0;
    slv_aw_i       = '0;
    slv_w_valid_i  = '0;
    slv_w_i        = '0;
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_i        = '0;
    aw_fire        = '0;
    w_fire         = '0;
    b_fire         = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    while (b_done < NUM_WRITES && cycle < MAX_CYCLES) @(posedge clk_i);
    if (b_done < NUM_WRITES) begin
      $display("Timeout after %0d cycles, %0d of %0d writes done", cycle, b_done, NUM_WRITES);
      timed_out = 1'b1;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        compare_value(0, $sformatf("master AWs of port %0d", p), n_mst[p], WRITES_PER_PORT);
        compare_value(2, $sformatf("B responses of port %0d", p), b_got[p], WRITES_PER_PORT);
        compare_value(4, $sformatf("grants of port %0d", p), n_acc[p], WRITES_PER_PORT);
      end
      compare_value(1, "completed W bursts", w_done, NUM_WRITES);
      check_true(3, max_out == MAX_W_TRANS,
                 $sformatf("%0d writes in flight during the W stall, not %0d", max_out, MAX_W_TRANS));
      check_true(3, aw_done > aw_stall_end, "no AW accepted after the W stall ended");
    end
    for (int t = 0; t < 5; t++) begin
      $display("Test %0d %s: %0d checks, %0d errors", t + 1, test_name[t], chk[t], err[t]);
      total_err += err[t];
      total_chk += chk[t];
    end
    $display("Summary: 5 tests, %0d checks, %0d errors", total_chk, total_err);
    if (!timed_out && total_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axi_wmux_top.f */
axi_mux_cfg_pkg.sv
axi_mux_chan_pkg.sv
aw_arbiter.sv
aw_lock_fsm.sv
w_order_fifo.sv
w_switch.sv
b_router.sv
axi_wmux_top.sv
tb_axi_wmux.sv

/* Bender.yml */
package:
  name: axi_wmux

sources:
  - axi_mux_cfg_pkg.sv
  - axi_mux_chan_pkg.sv
  - aw_arbiter.sv
  - aw_lock_fsm.sv
  - w_order_fifo.sv
  - w_switch.sv
  - b_router.sv
  - axi_wmux_top.sv
  - target: test
    files:
      - tb_axi_wmux.sv
